//--- verilog/gamePkg.sv
package gamePkg;

	// ###################################################################
	// vector types.
	// ###################################################################

	// screen coordinate in whole pixels.
	typedef logic signed [10:0] coordT;

	// position with 6 fraction bits.
	typedef logic signed [17:0] fixedT;

	// speed in 1/64 pixel per frame.
	typedef logic signed [11:0] speedT;

	// set of touched ball edges, left top right bottom.
	typedef logic [3:0] edgeCodeT;

	typedef logic [7:0] colorT;

	// ###################################################################
	// motion constants.
	// ###################################################################

	localparam int fracBits = 6;
	localparam int gravity = 1;
	localparam int maxYSpeed = 230;
	localparam int velocityLoss = 10;

	localparam int ballSize = 8;
	localparam int flipperWidth = 16;
	localparam int flipperHeight = 2;

	// bit positions inside edgeCodeT.
	localparam int edgeLeft = 3;
	localparam int edgeTop = 2;
	localparam int edgeRight = 1;
	localparam int edgeBottom = 0;

	// ###################################################################
	// colour codes, 3-3-2 rgb.
	// ###################################################################

	localparam colorT colorBackground = 8'h00;
	localparam colorT colorBorder = 8'hFF;
	localparam colorT colorFlipper = 8'h1C;

	// ball i takes entry i mod 4.
	localparam colorT ballColors [4] = '{8'hE0, 8'h03, 8'hFC, 8'hE3};

endpackage

//--- verilog/frameTiming.sv
`timescale 1ns/1ns

module frameTiming #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int blankLines = 45
) (
	input logic clk,
	input logic resetN,
	output gamePkg::coordT pixelX,
	output gamePkg::coordT pixelY,
	output logic visible,
	output logic startOfFrame
);
	import gamePkg::*;

	localparam coordT lastColumn = coordT'(screenWidth - 1);
	localparam coordT lastLine = coordT'(screenHeight + blankLines - 1);
	localparam coordT firstBlankLine = coordT'(screenHeight);

	// column and line counters, free running.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixelX <= '0;
			pixelY <= '0;
		end else begin
			if (pixelX == lastColumn) begin
				pixelX <= '0;
				if (pixelY == lastLine) begin
					pixelY <= '0;
				end else begin
					pixelY <= pixelY + coordT'(1);
				end
			end else begin
				pixelX <= pixelX + coordT'(1);
			end
		end
	end

	// lines at and below screenHeight form the blanking interval.
	assign visible = (pixelY < firstBlankLine);

	// frame boundary at the first pixel of the first blanking line.
	assign startOfFrame = (pixelX == coordT'(0)) && (pixelY == firstBlankLine);

endmodule

//--- verilog/ballDrawer.sv
`timescale 1ns/1ns

module ballDrawer (
	input gamePkg::coordT pixelX,
	input gamePkg::coordT pixelY,
	input gamePkg::coordT topLeftX,
	input gamePkg::coordT topLeftY,
	input logic visible,
	output logic ballHit,
	output gamePkg::edgeCodeT ballEdges
);
	import gamePkg::*;

	// one bit wider so that a ball far off screen does not wrap.
	logic signed [11:0] offsetX;
	logic signed [11:0] offsetY;
	logic insideX;
	logic insideY;

	assign offsetX = pixelX - topLeftX;
	assign offsetY = pixelY - topLeftY;

	assign insideX = (offsetX >= 0) && (offsetX < ballSize);
	assign insideY = (offsetY >= 0) && (offsetY < ballSize);

	assign ballHit = visible && insideX && insideY;

	// a corner pixel reports two edges.
	always_comb begin
		ballEdges = '0;
		if (ballHit) begin
			ballEdges[edgeLeft] = (offsetX == 0);
			ballEdges[edgeTop] = (offsetY == 0);
			ballEdges[edgeRight] = (offsetX == ballSize - 1);
			ballEdges[edgeBottom] = (offsetY == ballSize - 1);
		end
	end

endmodule

//--- verilog/ballController.sv
`timescale 1ns/1ns

module ballController #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int initialX = 100,
	parameter int initialY = 50,
	parameter int initialXSpeed = 40,
	parameter int initialYSpeed = 0
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic flipperBounce,
	input gamePkg::edgeCodeT hitEdges,
	output gamePkg::coordT topLeftX,
	output gamePkg::coordT topLeftY
);
	import gamePkg::*;

	// start position kept inside the screen.
	localparam int limitX = screenWidth - 1 - ballSize;
	localparam int limitY = screenHeight - 1 - ballSize;
	localparam int startX = (initialX > limitX) ? limitX : initialX;
	localparam int startY = (initialY > limitY) ? limitY : initialY;
	localparam fixedT resetX = fixedT'(startX << fracBits);
	localparam fixedT resetY = fixedT'(startY << fracBits);

	fixedT posX;
	fixedT posY;
	speedT xSpeed;
	speedT ySpeed;
	speedT xSpeedBounce;
	speedT ySpeedBounce;
	speedT ySpeedNext;
	logic floorHit;

	assign floorHit = hitEdges[edgeBottom] || flipperBounce;

	// ###################################################################
	// bounces from last frame's collisions.
	// ###################################################################

	always_comb begin
		xSpeedBounce = xSpeed;
		if (hitEdges[edgeLeft] && (xSpeed < 0)) begin
			xSpeedBounce = -xSpeed;
		end else if (hitEdges[edgeRight] && (xSpeed > 0)) begin
			xSpeedBounce = -xSpeed;
		end
	end

	always_comb begin
		ySpeedBounce = ySpeed;
		if (hitEdges[edgeTop] && (ySpeed < 0)) begin
			ySpeedBounce = -ySpeed;
		end else if (floorHit && (ySpeed > 0)) begin
			// a slow ball comes to rest.
			if (ySpeed <= speedT'(velocityLoss)) begin
				ySpeedBounce = '0;
			end else begin
				ySpeedBounce = speedT'(velocityLoss) - ySpeed;
			end
		end
	end

	// gravity up to the speed cap.
	assign ySpeedNext = (ySpeedBounce < speedT'(maxYSpeed)) ?
		ySpeedBounce + speedT'(gravity) : ySpeedBounce;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX <= resetX;
			posY <= resetY;
			xSpeed <= speedT'(initialXSpeed);
			ySpeed <= speedT'(initialYSpeed);
		end else if (startOfFrame) begin
			posX <= posX + fixedT'(xSpeedBounce);
			posY <= posY + fixedT'(ySpeedBounce);
			xSpeed <= xSpeedBounce;
			ySpeed <= ySpeedNext;
		end
	end

	assign topLeftX = coordT'(posX >>> fracBits);
	assign topLeftY = coordT'(posY >>> fracBits);

endmodule

//--- verilog/playfieldDrawer.sv
`timescale 1ns/1ns

module playfieldDrawer #(
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int flipperY = 440
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic moveLeft,
	input logic moveRight,
	input logic visible,
	input gamePkg::coordT pixelX,
	input gamePkg::coordT pixelY,
	output logic borderHit,
	output logic flipperHit
);
	import gamePkg::*;

	localparam coordT minFlipperX = coordT'(1);
	localparam coordT maxFlipperX = coordT'(screenWidth - 1 - flipperWidth);
	localparam coordT centreX = coordT'((screenWidth - flipperWidth) / 2);
	localparam coordT lastColumn = coordT'(screenWidth - 1);
	localparam coordT lastLine = coordT'(screenHeight - 1);
	localparam coordT flipperTop = coordT'(flipperY);

	coordT flipperX;

	// one pixel per frame, pressing both buttons holds the flipper.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			flipperX <= centreX;
		end else if (startOfFrame) begin
			if (moveLeft && !moveRight && (flipperX > minFlipperX)) begin
				flipperX <= flipperX - coordT'(1);
			end else if (moveRight && !moveLeft && (flipperX < maxFlipperX)) begin
				flipperX <= flipperX + coordT'(1);
			end
		end
	end

	assign borderHit = visible && ((pixelX == coordT'(0)) || (pixelX == lastColumn) ||
		(pixelY == coordT'(0)) || (pixelY == lastLine));

	assign flipperHit = visible &&
		(pixelX >= flipperX) && (pixelX < flipperX + coordT'(flipperWidth)) &&
		(pixelY >= flipperTop) && (pixelY < flipperTop + coordT'(flipperHeight));

endmodule

//--- verilog/collisionArbiter.sv
`timescale 1ns/1ns

module collisionArbiter #(
	parameter int numBalls = 2
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic visible,
	input logic borderHit,
	input logic flipperHit,
	input gamePkg::coordT pixelX,
	input gamePkg::coordT pixelY,
	input logic [numBalls-1:0] ballHits,
	input gamePkg::edgeCodeT [numBalls-1:0] ballEdgeCodes,
	output gamePkg::edgeCodeT [numBalls-1:0] hitEdges,
	output logic [numBalls-1:0] flipperBounce,
	output gamePkg::coordT pixelOutX,
	output gamePkg::coordT pixelOutY,
	output gamePkg::colorT rgb,
	output logic pixelValid
);
	import gamePkg::*;

	logic [numBalls-1:0] borderTouch;
	logic [numBalls-1:0] flipperTouch;
	colorT pixelColor;

	// ###################################################################
	// per-frame collision sets.
	// ###################################################################

	// only the ball's bottom edge counts on the flipper.
	always_comb begin
		for (int i = 0; i < numBalls; i++) begin
			borderTouch[i] = visible && ballHits[i] && borderHit;
			flipperTouch[i] = visible && ballHits[i] && flipperHit &&
				ballEdgeCodes[i][edgeBottom];
		end
	end

	// the controllers sample the sets on the same startOfFrame edge.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hitEdges <= '0;
			flipperBounce <= '0;
		end else if (startOfFrame) begin
			hitEdges <= '0;
			flipperBounce <= '0;
		end else begin
			for (int i = 0; i < numBalls; i++) begin
				if (borderTouch[i]) begin
					hitEdges[i] <= hitEdges[i] | ballEdgeCodes[i];
				end
				if (flipperTouch[i]) begin
					flipperBounce[i] <= 1'b1;
				end
			end
		end
	end

	// ###################################################################
	// colour priority and output register.
	// ###################################################################

	// walk down so that the lowest index ball wins.
	always_comb begin
		pixelColor = colorBackground;
		if (borderHit) begin
			pixelColor = colorBorder;
		end
		if (flipperHit) begin
			pixelColor = colorFlipper;
		end
		for (int i = numBalls - 1; i >= 0; i--) begin
			if (ballHits[i]) begin
				pixelColor = ballColors[i % 4];
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixelValid <= 1'b0;
		end else begin
			pixelValid <= visible;
		end
	end

	always_ff @(posedge clk) begin
		pixelOutX <= pixelX;
		pixelOutY <= pixelY;
		rgb <= pixelColor;
	end

endmodule

//--- verilog/pinballTop.sv
`timescale 1ns/1ns

module pinballTop #(
	parameter int numBalls = 2,
	parameter int screenWidth = 640,
	parameter int screenHeight = 480,
	parameter int blankLines = 45,
	parameter int ballStartX = 100,
	parameter int ballStartY = 50,
	parameter int ballSpacing = 120,
	parameter int startXSpeed = 40,
	parameter int startYSpeed = 0,
	parameter int flipperY = 440
) (
	input logic clk,
	input logic resetN,
	input logic moveLeft,
	input logic moveRight,
	output gamePkg::coordT pixelOutX,
	output gamePkg::coordT pixelOutY,
	output gamePkg::colorT rgb,
	output logic pixelValid
);
	import gamePkg::*;

	coordT pixelX;
	coordT pixelY;
	logic visible;
	logic startOfFrame;
	logic borderHit;
	logic flipperHit;
	logic [numBalls-1:0] ballHits;
	edgeCodeT [numBalls-1:0] ballEdgeCodes;
	edgeCodeT [numBalls-1:0] hitEdges;
	logic [numBalls-1:0] flipperBounce;

	frameTiming #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.blankLines(blankLines)
	) i_frameTiming (
		.clk(clk),
		.resetN(resetN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.visible(visible),
		.startOfFrame(startOfFrame)
	);

	playfieldDrawer #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.flipperY(flipperY)
	) i_playfieldDrawer (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.visible(visible),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.borderHit(borderHit),
		.flipperHit(flipperHit)
	);

	// ###################################################################
	// one controller and drawer per ball.
	// ###################################################################

	// odd balls start moving to the left.
	for (genvar i = 0; i < numBalls; i++) begin : gBall
		coordT topLeftX;
		coordT topLeftY;

		ballController #(
			.screenWidth(screenWidth),
			.screenHeight(screenHeight),
			.initialX(ballStartX + i * ballSpacing),
			.initialY(ballStartY),
			.initialXSpeed((i % 2 == 0) ? startXSpeed : -startXSpeed),
			.initialYSpeed(startYSpeed)
		) i_ballController (
			.clk(clk),
			.resetN(resetN),
			.startOfFrame(startOfFrame),
			.flipperBounce(flipperBounce[i]),
			.hitEdges(hitEdges[i]),
			.topLeftX(topLeftX),
			.topLeftY(topLeftY)
		);

		ballDrawer i_ballDrawer (
			.pixelX(pixelX),
			.pixelY(pixelY),
			.topLeftX(topLeftX),
			.topLeftY(topLeftY),
			.visible(visible),
			.ballHit(ballHits[i]),
			.ballEdges(ballEdgeCodes[i])
		);
	end

	collisionArbiter #(
		.numBalls(numBalls)
	) i_collisionArbiter (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.visible(visible),
		.borderHit(borderHit),
		.flipperHit(flipperHit),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.ballHits(ballHits),
		.ballEdgeCodes(ballEdgeCodes),
		.hitEdges(hitEdges),
		.flipperBounce(flipperBounce),
		.pixelOutX(pixelOutX),
		.pixelOutY(pixelOutY),
		.rgb(rgb),
		.pixelValid(pixelValid)
	);

endmodule

//--- testbench/tbChecker.sv
`timescale 1ns/1ns

module tbChecker #(
	parameter int numBalls = 2,
	parameter int screenWidth = 64,
	parameter int screenHeight = 48,
	parameter int ballStartX = 24,
	parameter int ballStartY = 6,
	parameter int ballSpacing = 8,
	parameter int startXSpeed = 32,
	parameter int startYSpeed = -48,
	parameter int flipperY = 40
) (
	input logic clk,
	input logic resetN,
	input logic moveLeft,
	input logic moveRight,
	input gamePkg::coordT pixelOutX,
	input gamePkg::coordT pixelOutY,
	input gamePkg::colorT rgb,
	input logic pixelValid,
	input logic rowDone,
	input int rowFlipperX,
	output int framesDone,
	output int rowsReported,
	output int rowErrors,
	output int errKind,
	output int errExpected,
	output int errActual
);
	import gamePkg::*;

	// model of the game state.
	fixedT posX [numBalls];
	fixedT posY [numBalls];
	speedT xSpeed [numBalls];
	speedT ySpeed [numBalls];
	edgeCodeT touched [numBalls];
	logic onFlipper [numBalls];
	int flipperX;

	// next pixel expected on the output.
	int scanX;
	int scanY;

	int errors;
	int firstKind;
	int firstExpected;
	int firstActual;

	// whole pixel part of a fixed-point position.
	function automatic int pixelOf(fixedT pos);
		coordT whole;
		whole = coordT'(pos >>> fracBits);
		return int'(whole);
	endfunction

	task automatic resetModel();
		for (int i = 0; i < numBalls; i++) begin
			posX[i] = fixedT'((ballStartX + i * ballSpacing) * (1 << fracBits));
			posY[i] = fixedT'(ballStartY * (1 << fracBits));
			xSpeed[i] = speedT'((i % 2 == 0) ? startXSpeed : -startXSpeed);
			ySpeed[i] = speedT'(startYSpeed);
			touched[i] = '0;
			onFlipper[i] = 1'b0;
		end
		flipperX = (screenWidth - flipperWidth) / 2;
		scanX = 0;
		scanY = 0;
		errors = 0;
		framesDone = 0;
		rowsReported = 0;
	endtask

	task automatic recordError(int kind, int expectedValue, int actualValue);
		if (errors == 0) begin
			firstKind = kind;
			firstExpected = expectedValue;
			firstActual = actualValue;
		end
		errors++;
	endtask

	// ###################################################################
	// per-frame motion rules.
	// ###################################################################

	task automatic endFrame();
		speedT xs;
		speedT ys;
		for (int i = 0; i < numBalls; i++) begin
			xs = xSpeed[i];
			ys = ySpeed[i];
			if (touched[i][edgeLeft] && (xs < 0)) begin
				xs = -xs;
			end else if (touched[i][edgeRight] && (xs > 0)) begin
				xs = -xs;
			end
			if (touched[i][edgeTop] && (ys < 0)) begin
				ys = -ys;
			end else if ((touched[i][edgeBottom] || onFlipper[i]) && (ys > 0)) begin
				if (ys <= velocityLoss) begin
					ys = 0;
				end else begin
					ys = -(ys - velocityLoss);
				end
			end
			posX[i] = posX[i] + fixedT'(xs);
			posY[i] = posY[i] + fixedT'(ys);
			if (ys < maxYSpeed) begin
				ys = ys + gravity;
			end
			xSpeed[i] = xs;
			ySpeed[i] = ys;
			touched[i] = '0;
			onFlipper[i] = 1'b0;
		end
		if (moveLeft && !moveRight && (flipperX > 1)) begin
			flipperX--;
		end else if (moveRight && !moveLeft && (flipperX < screenWidth - 1 - flipperWidth)) begin
			flipperX++;
		end
		framesDone++;
	endtask

	// ###################################################################
	// pixel rendering and compare.
	// ###################################################################

	task automatic checkPixel();
		int dx;
		int dy;
		logic border;
		logic flipper;
		logic found;
		edgeCodeT edges;
		colorT expected;
		border = (scanX == 0) || (scanX == screenWidth - 1) ||
			(scanY == 0) || (scanY == screenHeight - 1);
		flipper = (scanX >= flipperX) && (scanX < flipperX + flipperWidth) &&
			(scanY >= flipperY) && (scanY < flipperY + flipperHeight);
		expected = border ? colorBorder : colorBackground;
		if (flipper) begin
			expected = colorFlipper;
		end
		found = 1'b0;
		for (int i = 0; i < numBalls; i++) begin
			dx = scanX - pixelOf(posX[i]);
			dy = scanY - pixelOf(posY[i]);
			if ((dx >= 0) && (dx < ballSize) && (dy >= 0) && (dy < ballSize)) begin
				edges = '0;
				edges[edgeLeft] = (dx == 0);
				edges[edgeTop] = (dy == 0);
				edges[edgeRight] = (dx == ballSize - 1);
				edges[edgeBottom] = (dy == ballSize - 1);
				if (border) begin
					touched[i] = touched[i] | edges;
				end
				if (flipper && edges[edgeBottom]) begin
					onFlipper[i] = 1'b1;
				end
				// lower index wins.
				if (!found) begin
					expected = ballColors[i % 4];
				end
				found = 1'b1;
			end
		end
		if ((int'(pixelOutX) != scanX) || (int'(pixelOutY) != scanY)) begin
			recordError(2, scanY * screenWidth + scanX,
				int'(pixelOutY) * screenWidth + int'(pixelOutX));
		end else if (rgb !== expected) begin
			recordError(1, int'(expected), int'(rgb));
		end
		if (scanX == screenWidth - 1) begin
			scanX = 0;
			if (scanY == screenHeight - 1) begin
				scanY = 0;
				endFrame();
			end else begin
				scanY++;
			end
		end else begin
			scanX++;
		end
	endtask

	task automatic reportRow();
		if (flipperX != rowFlipperX) begin
			recordError(3, rowFlipperX, flipperX);
		end
		rowErrors = errors;
		errKind = firstKind;
		errExpected = firstExpected;
		errActual = firstActual;
		errors = 0;
		rowsReported++;
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk) begin
		if (!resetN) begin
			resetModel();
		end else begin
			if (pixelValid) begin
				checkPixel();
			end
			if (rowDone) begin
				reportRow();
			end
		end
	end

endmodule

//--- testbench/tbPinball.sv
`timescale 1ns/1ns

module tbPinball;
	import gamePkg::*;

	localparam int numBalls = 2;
	localparam int screenWidth = 64;
	localparam int screenHeight = 48;
	localparam int blankLines = 2;
	localparam int ballStartX = 24;
	localparam int ballStartY = 6;
	localparam int ballSpacing = 8;
	localparam int startXSpeed = 32;
	localparam int startYSpeed = -48;
	localparam int flipperY = 40;
	localparam int numRows = 8;

	// ###################################################################
	// stimulus table.
	// ###################################################################

	// name, moveLeft, moveRight, frames, flipper x after the row.
	string rowNames [numRows] = '{"reset", "idle", "rightClamp", "bothButtons",
		"left", "fallIdle", "leftClamp", "drift"};
	logic rowLeft [numRows] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
	logic rowRight [numRows] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
	int rowFrames [numRows] = '{1, 12, 30, 6, 20, 40, 30, 30};
	int rowFlipper [numRows] = '{24, 24, 47, 47, 27, 27, 1, 1};

	logic clk;
	logic resetN;
	logic moveLeft;
	logic moveRight;
	coordT pixelOutX;
	coordT pixelOutY;
	colorT rgb;
	logic pixelValid;

	logic rowDone;
	int rowFlipperX;
	int framesDone;
	int rowsReported;
	int rowErrors;
	int errKind;
	int errExpected;
	int errActual;
	int passed;
	int failed;
	int target;
	int cycles;
	int cycleLimit;

	pinballTop #(
		.numBalls(numBalls),
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.blankLines(blankLines),
		.ballStartX(ballStartX),
		.ballStartY(ballStartY),
		.ballSpacing(ballSpacing),
		.startXSpeed(startXSpeed),
		.startYSpeed(startYSpeed),
		.flipperY(flipperY)
	) i_pinballTop (
		.clk(clk),
		.resetN(resetN),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.pixelOutX(pixelOutX),
		.pixelOutY(pixelOutY),
		.rgb(rgb),
		.pixelValid(pixelValid)
	);

	tbChecker #(
		.numBalls(numBalls),
		.screenWidth(screenWidth),
		.screenHeight(screenHeight),
		.ballStartX(ballStartX),
		.ballStartY(ballStartY),
		.ballSpacing(ballSpacing),
		.startXSpeed(startXSpeed),
		.startYSpeed(startYSpeed),
		.flipperY(flipperY)
	) i_tbChecker (
		.clk(clk),
		.resetN(resetN),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.pixelOutX(pixelOutX),
		.pixelOutY(pixelOutY),
		.rgb(rgb),
		.pixelValid(pixelValid),
		.rowDone(rowDone),
		.rowFlipperX(rowFlipperX),
		.framesDone(framesDone),
		.rowsReported(rowsReported),
		.rowErrors(rowErrors),
		.errKind(errKind),
		.errExpected(errExpected),
		.errActual(errActual)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic printRow(int row);
		if (rowErrors == 0) begin
			$display("test %0s passed after %0d frames", rowNames[row], rowFrames[row]);
			passed++;
		end else begin
			if (errKind == 1) begin
				$display("ERROR %0s: colour expected 0x%0h actual 0x%0h, %0d mismatches",
					rowNames[row], errExpected, errActual, rowErrors);
			end else if (errKind == 2) begin
				$display("ERROR %0s: pixel index expected %0d actual %0d, %0d mismatches",
					rowNames[row], errExpected, errActual, rowErrors);
			end else begin
				$display("ERROR %0s: flipper x expected %0d actual %0d",
					rowNames[row], errExpected, errActual);
			end
			failed++;
		end
	endtask

	// ###################################################################
	// main sequence.
	// ###################################################################

	initial begin
		resetN = 1'b0;
		moveLeft = 1'b0;
		moveRight = 1'b0;
		rowDone = 1'b0;
		rowFlipperX = 0;
		passed = 0;
		failed = 0;
		repeat (5) @(posedge clk);
		resetN <= 1'b1;
		for (int row = 0; row < numRows; row++) begin
			target = framesDone + rowFrames[row];
			moveLeft <= rowLeft[row];
			moveRight <= rowRight[row];
			while (framesDone < target) @(posedge clk);
			rowFlipperX <= rowFlipper[row];
			rowDone <= 1'b1;
			@(posedge clk);
			rowDone <= 1'b0;
			while (rowsReported < row + 1) @(posedge clk);
			printRow(row);
		end
		$display("%0d of %0d tests passed, %0d failed", passed, numRows, failed);
		if ((failed == 0) && (passed == numRows)) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// each frame is given a little more than its real length.
	initial begin
		cycleLimit = 1000;
		for (int row = 0; row < numRows; row++) begin
			cycleLimit += rowFrames[row] * (screenWidth + 2) * (screenHeight + blankLines);
		end
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the frames did not complete within %0d clock cycles", cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- flist.f
verilog/gamePkg.sv
verilog/frameTiming.sv
verilog/ballDrawer.sv
verilog/ballController.sv
verilog/playfieldDrawer.sv
verilog/collisionArbiter.sv
verilog/pinballTop.sv
testbench/tbChecker.sv
testbench/tbPinball.sv
